// ==== bench/pcs_rx_model.svh ====
//////////////////////////////
// Receive PCS reference model
// LCG step, serial scrambler and descrambler
// 66b block to XGMII decode
//////////////////////////////

`ifndef PCS_RX_MODEL_SVH
`define PCS_RX_MODEL_SVH

localparam logic [7:0] TERM_CODES [8] = '{
    BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
    BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7
};

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// Serial x^58 + x^39 + 1, shift register bit k is the line bit k+1 places back
function automatic logic [PAYLOAD_W-1:0] scr_serial(
    input logic [PAYLOAD_W-1:0] din,
    input logic [PAYLOAD_W-1:0] hist,
    input logic                 descramble
);
    logic [SCR_LEN-1:0]   sr;
    logic [PAYLOAD_W-1:0] dout;
    for (int k = 0; k < SCR_LEN; k++) begin
        sr[k] = hist[PAYLOAD_W-1-k];
    end
    for (int i = 0; i < PAYLOAD_W; i++) begin
        dout[i] = din[i] ^ sr[SCR_TAP-1] ^ sr[SCR_LEN-1];
        // Line bit is shifted in either way
        sr = {sr[SCR_LEN-2:0], descramble ? din[i] : dout[i]};
    end
    return dout;
endfunction

// Data bytes before the terminate, or -1 for other type bytes
function automatic int term_bytes(input logic [7:0] t);
    for (int n = 0; n < 8; n++) begin
        if (t == TERM_CODES[n]) begin
            return n;
        end
    end
    return -1;
endfunction

// Returns control word above data
function automatic logic [XGMII_C_W+PAYLOAD_W-1:0] decode_block(
    input logic [HDR_W-1:0]     hdr,
    input logic [PAYLOAD_W-1:0] pl,
    input logic                 after_term
);
    logic [XGMII_C_W-1:0] c;
    logic [PAYLOAD_W-1:0] d;
    int                   n;
    c = 8'hFF;
    d = {8{XG_ERROR}};
    n = term_bytes(pl[7:0]);
    if (hdr == HDR_DATA && !after_term) begin
        c = 8'h00;
        d = pl;
    end else if (hdr == HDR_CTRL && pl[7:0] == BT_IDLE) begin
        d = {8{XG_IDLE}};
    end else if (hdr == HDR_CTRL && pl[7:0] == BT_START && !after_term) begin
        c = 8'h01;
        d = {pl[63:8], XG_START};
    end else if (hdr == HDR_CTRL && n >= 0) begin
        for (int j = 0; j < 8; j++) begin
            c[j] = (j >= n);
            if (j < n) begin
                d[8*j +: 8] = pl[8*(j+1) +: 8];
            end else begin
                d[8*j +: 8] = (j == n) ? XG_TERM : XG_IDLE;
            end
        end
    end
    return {c, d};
endfunction

`endif

// ==== bench/pcs_rx_tb.sv ====
//////////////////////////////
// Receive PCS testbench
// Random and directed 66b groups
// checked against the reference model
//////////////////////////////

`timescale 1ns/1ps

module pcs_rx_tb;

    import pcs_rx_pkg::*;

    `include "pcs_rx_model.svh"

    localparam int          NUM_LANES      = 4;
    localparam logic [31:0] SEED           = 32'h2d16_7bed;
    localparam int          N_IDLE         = 8;
    localparam int          N_BYPASS       = 60;
    localparam int          N_SCRAM        = 400;
    // Reset, pipe clearing, directed groups and margin
    localparam int          TIMEOUT_CYCLES = 2*N_IDLE + N_BYPASS + N_SCRAM + 60;

    logic                 rx_clk_161_13 = 1'b0;
    logic                 async_reset_n;
    logic                 rx_valid_i;
    logic [HDR_W-1:0]     rx_header_i [NUM_LANES];
    logic [PAYLOAD_W-1:0] rx_data_i   [NUM_LANES];
    logic [1:0]           lane_rot_i;
    logic                 bypass_descram_i;
    logic                 xgmii_valid_o;
    logic [XGMII_C_W-1:0] xgmii_rxc_o [NUM_LANES];
    logic [PAYLOAD_W-1:0] xgmii_rxd_o [NUM_LANES];

    // Next group in stream order, before scrambling
    logic [HDR_W-1:0]     blk_hdr   [NUM_LANES];
    logic [PAYLOAD_W-1:0] blk_plain [NUM_LANES];

    logic                           exp_valid_q [$];
    logic [NUM_LANES*XGMII_C_W-1:0] exp_rxc_q   [$];
    logic [NUM_LANES*PAYLOAD_W-1:0] exp_rxd_q   [$];

    logic [31:0]          rng = SEED;
    logic [PAYLOAD_W-1:0] prev_line;
    int                   err_cnt = 0;
    int                   chk_cnt = 0;
    int                   cycle_cnt = 0;

    pcs_rx_top #(
        .NUM_LANES (NUM_LANES)
    ) dut_i (
        .rx_clk_161_13    (rx_clk_161_13),
        .async_reset_n    (async_reset_n),
        .rx_valid_i       (rx_valid_i),
        .rx_header_i      (rx_header_i),
        .rx_data_i        (rx_data_i),
        .lane_rot_i       (lane_rot_i),
        .bypass_descram_i (bypass_descram_i),
        .xgmii_valid_o    (xgmii_valid_o),
        .xgmii_rxc_o      (xgmii_rxc_o),
        .xgmii_rxd_o      (xgmii_rxd_o)
    );

    always #2 rx_clk_161_13 = ~rx_clk_161_13;

    always @(posedge rx_clk_161_13) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] draw();
        rng = lcg_next(rng);
        return rng;
    endfunction

    function automatic logic [PAYLOAD_W-1:0] draw64();
        logic [31:0] hi;
        hi = draw();
        return {hi, draw()};
    endfunction

    task automatic set_data(input int k);
        blk_hdr[k]   = HDR_DATA;
        blk_plain[k] = draw64();
    endtask

    task automatic set_ctrl(input int k, input logic [7:0] btype);
        logic [PAYLOAD_W-1:0] p;
        p            = draw64();
        blk_hdr[k]   = HDR_CTRL;
        blk_plain[k] = {p[63:8], btype};
    endtask

    // Mostly data, with every control kind and bad blocks mixed in
    task automatic set_random(input int k);
        logic [31:0] r;
        logic [7:0]  t;
        r = draw();
        t = r[7:0];
        case (r[27:24])
            4'd9: set_ctrl(k, BT_IDLE);
            4'd10: set_ctrl(k, BT_START);
            4'd11, 4'd12: set_ctrl(k, TERM_CODES[r[2:0]]);
            4'd13: begin
                set_data(k);
                blk_hdr[k] = {r[0], r[0]};
            end
            4'd14: begin
                while (term_bytes(t) >= 0 || t == BT_IDLE || t == BT_START) begin
                    t = t + 8'd1;
                end
                set_ctrl(k, t);
            end
            default: set_data(k);
        endcase
    endtask

    task automatic expect_group(input logic v, input logic [NUM_LANES*XGMII_C_W-1:0] c,
                                input logic [NUM_LANES*PAYLOAD_W-1:0] d);
        exp_valid_q.push_back(v);
        exp_rxc_q.push_back(c);
        exp_rxd_q.push_back(d);
    endtask

    task automatic check_outputs();
        logic                           v;
        logic [NUM_LANES*XGMII_C_W-1:0] c;
        logic [NUM_LANES*PAYLOAD_W-1:0] d;
        v = exp_valid_q.pop_front();
        c = exp_rxc_q.pop_front();
        d = exp_rxd_q.pop_front();
        chk_cnt++;
        if (xgmii_valid_o !== v) begin
            err_cnt++;
            $display("error at %0t: xgmii_valid_o expected %b got %b", $time, v, xgmii_valid_o);
        end
        for (int k = 0; k < NUM_LANES; k++) begin
            if (v && xgmii_rxc_o[k] !== c[XGMII_C_W*k +: XGMII_C_W]) begin
                err_cnt++;
                $display("error at %0t: xgmii_rxc_o[%0d] expected %h got %h", $time, k,
                         c[XGMII_C_W*k +: XGMII_C_W], xgmii_rxc_o[k]);
            end
            if (v && xgmii_rxd_o[k] !== d[PAYLOAD_W*k +: PAYLOAD_W]) begin
                err_cnt++;
                $display("error at %0t: xgmii_rxd_o[%0d] expected %h got %h", $time, k,
                         d[PAYLOAD_W*k +: PAYLOAD_W], xgmii_rxd_o[k]);
            end
        end
    endtask

    // Check the group from two cycles back, then drive the next one
    task automatic send_cycle(input logic valid, input logic bypass, input logic [1:0] rot);
        logic [PAYLOAD_W-1:0]           hist;
        logic [PAYLOAD_W-1:0]           line;
        logic [PAYLOAD_W-1:0]           plain;
        logic [XGMII_C_W+PAYLOAD_W-1:0] dec;
        logic [NUM_LANES*XGMII_C_W-1:0] c;
        logic [NUM_LANES*PAYLOAD_W-1:0] d;
        logic                           after;
        int                             lane;
        @(negedge rx_clk_161_13);
        check_outputs();
        hist  = prev_line;
        after = 1'b0;
        c     = '0;
        d     = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            lane = (k + int'(rot)) % NUM_LANES;
            if (valid) begin
                line  = bypass ? blk_plain[k] : scr_serial(blk_plain[k], hist, 1'b0);
                // Receive side of the model works from the line bits
                plain = bypass ? line : scr_serial(line, hist, 1'b1);
                hist  = line;
                dec   = decode_block(blk_hdr[k], plain, after);
                c[XGMII_C_W*k +: XGMII_C_W] = dec[PAYLOAD_W +: XGMII_C_W];
                d[PAYLOAD_W*k +: PAYLOAD_W] = dec[PAYLOAD_W-1:0];
                if (blk_hdr[k] == HDR_CTRL && term_bytes(plain[7:0]) >= 0) begin
                    after = 1'b1;
                end
                rx_header_i[lane] = blk_hdr[k];
            end else begin
                // Garbage that the DUT must ignore
                line = draw64();
                rx_header_i[lane] = line[1:0];
            end
            rx_data_i[lane] = line;
        end
        prev_line        = hist;
        rx_valid_i       = valid;
        lane_rot_i       = rot;
        bypass_descram_i = bypass;
        expect_group(valid, c, d);
    endtask

    task automatic run_random(input int n, input logic bypass);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = draw();
            for (int k = 0; k < NUM_LANES; k++) begin
                if (bypass) begin
                    set_data(k);
                end else begin
                    set_random(k);
                end
            end
            send_cycle(r[17:16] != 2'b00, bypass, r[21:20]);
        end
    endtask

    initial begin
        async_reset_n    = 1'b0;
        rx_valid_i       = 1'b0;
        lane_rot_i       = 2'd0;
        bypass_descram_i = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            rx_header_i[k] = '0;
            rx_data_i[k]   = '0;
        end
        prev_line = '0;
        repeat (2) @(posedge rx_clk_161_13);
        @(negedge rx_clk_161_13);
        async_reset_n = 1'b1;
        // Two empty groups already in the pipe
        expect_group(1'b0, '0, '0);
        expect_group(1'b0, '0, '0);

        run_random(N_IDLE, 1'b0);
        for (int i = 0; i < N_IDLE; i++) begin
            send_cycle(1'b0, 1'b0, 2'd0);
        end
        run_random(N_BYPASS, 1'b1);
        send_cycle(1'b0, 1'b1, 2'd0);
        send_cycle(1'b0, 1'b0, 2'd0);
        run_random(N_SCRAM, 1'b0);

        //////////////////////////////
        // Directed groups
        for (int k = 0; k < NUM_LANES; k++) begin
            set_ctrl(k, TERM_CODES[k]);
        end
        send_cycle(1'b1, 1'b0, 2'd0);
        for (int k = 0; k < NUM_LANES; k++) begin
            set_ctrl(k, TERM_CODES[k+4]);
        end
        send_cycle(1'b1, 1'b0, 2'd1);
        // Data and start behind a terminate
        set_ctrl(0, BT_TERM3);
        set_data(1);
        set_ctrl(2, BT_START);
        set_ctrl(3, BT_IDLE);
        send_cycle(1'b1, 1'b0, 2'd3);
        set_ctrl(0, BT_START);
        for (int k = 1; k < NUM_LANES; k++) begin
            set_data(k);
        end
        send_cycle(1'b1, 1'b0, 2'd2);
        // Bad headers and unknown type bytes
        set_data(0);
        blk_hdr[0] = 2'b00;
        set_data(1);
        blk_hdr[1] = 2'b11;
        set_ctrl(2, 8'h55);
        set_ctrl(3, 8'h00);
        send_cycle(1'b1, 1'b0, 2'd1);
        send_cycle(1'b0, 1'b0, 2'd0);
        send_cycle(1'b0, 1'b0, 2'd0);

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== pcs_rx_top.f ====
+incdir+bench
rtl/pcs_rx_pkg.sv
rtl/lane_reorder.sv
rtl/rx_descrambler.sv
rtl/block_decoder.sv
rtl/pcs_rx_top.sv
bench/pcs_rx_tb.sv

// ==== rtl/block_decoder.sv ====
//////////////////////////////
// 66b block decoder for one lane
// Block classification, terminate chain
// Registered XGMII control and data
//////////////////////////////

`timescale 1ns/1ps

module block_decoder (
    input  logic                                rx_clk_161_13,
    input  logic                                async_reset_n,

    input  logic                                valid_i,
    input  logic [pcs_rx_pkg::HDR_W-1:0]        header_i,
    input  logic [pcs_rx_pkg::PAYLOAD_W-1:0]    data_i,
    input  logic                                term_i,
    output logic                                term_o,

    output logic                                xgmii_valid_o,
    output logic [pcs_rx_pkg::XGMII_C_W-1:0]    xgmii_rxc_o,
    output logic [pcs_rx_pkg::PAYLOAD_W-1:0]    xgmii_rxd_o
);

    import pcs_rx_pkg::*;

    localparam int BYTE_W = PAYLOAD_W / XGMII_C_W;

    logic [7:0]             type_byte;
    logic [PAYLOAD_W-1:0]   payload_sh;
    block_kind_e            kind_raw;
    block_kind_e            kind;
    logic [2:0]             term_n;
    logic [XGMII_C_W-1:0]   rxc_nxt;
    logic [PAYLOAD_W-1:0]   rxd_nxt;

    assign type_byte  = data_i[7:0];
    // Control block payload without its type byte
    assign payload_sh = data_i >> BYTE_W;

    //////////////////////////////
    // Block classification
    always_comb begin
        kind_raw = BLK_ERROR;
        term_n   = 3'd0;
        if (header_i == HDR_DATA) begin
            kind_raw = BLK_DATA;
        end else if (header_i == HDR_CTRL) begin
            case (type_byte)
                BT_IDLE: begin
                    kind_raw = BLK_IDLE;
                end
                BT_START: begin
                    kind_raw = BLK_START;
                end
                BT_TERM0: begin
                    kind_raw = BLK_TERM;
                    term_n   = 3'd0;
                end
                BT_TERM1: begin
                    kind_raw = BLK_TERM;
                    term_n   = 3'd1;
                end
                BT_TERM2: begin
                    kind_raw = BLK_TERM;
                    term_n   = 3'd2;
                end
                BT_TERM3: begin
                    kind_raw = BLK_TERM;
                    term_n   = 3'd3;
                end
                BT_TERM4: begin
                    kind_raw = BLK_TERM;
                    term_n   = 3'd4;
                end
                BT_TERM5: begin
                    kind_raw = BLK_TERM;
                    term_n   = 3'd5;
                end
                BT_TERM6: begin
                    kind_raw = BLK_TERM;
                    term_n   = 3'd6;
                end
                BT_TERM7: begin
                    kind_raw = BLK_TERM;
                    term_n   = 3'd7;
                end
                default: begin
                    kind_raw = BLK_ERROR;
                end
            endcase
        end
    end

    // Data or start after an earlier terminate in the same group
    assign kind = (term_i && (kind_raw == BLK_DATA || kind_raw == BLK_START)) ?
                  BLK_ERROR : kind_raw;

    assign term_o = term_i | (kind == BLK_TERM);

    //////////////////////////////
    // XGMII mapping
    always_comb begin
        rxc_nxt = {XGMII_C_W{1'b1}};
        rxd_nxt = {XGMII_C_W{XG_ERROR}};
        case (kind)
            BLK_DATA: begin
                rxc_nxt = '0;
                rxd_nxt = data_i;
            end
            BLK_IDLE: begin
                rxc_nxt = {XGMII_C_W{1'b1}};
                rxd_nxt = {XGMII_C_W{XG_IDLE}};
            end
            BLK_START: begin
                rxc_nxt = 8'h01;
                rxd_nxt = {data_i[PAYLOAD_W-1:BYTE_W], XG_START};
            end
            BLK_TERM: begin
                for (int j = 0; j < XGMII_C_W; j++) begin
                    if (j < int'(term_n)) begin
                        rxc_nxt[j]                = 1'b0;
                        rxd_nxt[BYTE_W*j +: BYTE_W] = payload_sh[BYTE_W*j +: BYTE_W];
                    end else if (j == int'(term_n)) begin
                        rxc_nxt[j]                = 1'b1;
                        rxd_nxt[BYTE_W*j +: BYTE_W] = XG_TERM;
                    end else begin
                        rxc_nxt[j]                = 1'b1;
                        rxd_nxt[BYTE_W*j +: BYTE_W] = XG_IDLE;
                    end
                end
            end
            default: begin
                rxc_nxt = {XGMII_C_W{1'b1}};
                rxd_nxt = {XGMII_C_W{XG_ERROR}};
            end
        endcase
    end

    // Output register
    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            xgmii_valid_o <= 1'b0;
        end else begin
            xgmii_valid_o <= valid_i;
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (valid_i) begin
            xgmii_rxc_o <= rxc_nxt;
            xgmii_rxd_o <= rxd_nxt;
        end
    end

    //////////////////////////////
    // Checks
    // Once a terminate is seen, the lane ends in a control byte
    a_term_chain: assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        valid_i && term_o |=> xgmii_rxc_o[XGMII_C_W-1]
    ) else $error("data byte in top lane byte after terminate");

endmodule

// ==== rtl/lane_reorder.sv ====
//////////////////////////////
// Input register with lane rotation
// Holds last stream block of the
// previous valid cycle as history
//////////////////////////////

`timescale 1ns/1ps

module lane_reorder #(
    parameter int NUM_LANES = 4
) (
    input  logic                                rx_clk_161_13,
    input  logic                                async_reset_n,

    input  logic                                rx_valid_i,
    input  logic [pcs_rx_pkg::HDR_W-1:0]        rx_header_i [NUM_LANES],
    input  logic [pcs_rx_pkg::PAYLOAD_W-1:0]    rx_data_i   [NUM_LANES],
    input  logic [1:0]                          lane_rot_i,

    output logic                                ord_valid_o,
    output logic [pcs_rx_pkg::HDR_W-1:0]        ord_header_o [NUM_LANES],
    output logic [pcs_rx_pkg::PAYLOAD_W-1:0]    ord_data_o   [NUM_LANES],
    output logic [pcs_rx_pkg::PAYLOAD_W-1:0]    prev_data_o
);

    import pcs_rx_pkg::*;

    // Set once ord_data_o holds a real block
    logic primed;

    //////////////////////////////
    // Control and history
    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            ord_valid_o <= 1'b0;
            primed      <= 1'b0;
            prev_data_o <= '0;
        end else begin
            ord_valid_o <= rx_valid_i;
            if (rx_valid_i) begin
                primed <= 1'b1;
                // Outgoing last lane becomes history of the new group
                if (primed) begin
                    prev_data_o <= ord_data_o[NUM_LANES-1];
                end
            end
        end
    end

    // Stream block k sits on input lane (k + rot) mod NUM_LANES
    always_ff @(posedge rx_clk_161_13) begin
        if (rx_valid_i) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                ord_header_o[k] <= rx_header_i[(k + int'(lane_rot_i)) % NUM_LANES];
                ord_data_o[k]   <= rx_data_i[(k + int'(lane_rot_i)) % NUM_LANES];
            end
        end
    end

    //////////////////////////////
    // Checks
    a_ord_valid_known: assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        !$isunknown(ord_valid_o)
    ) else $error("ord_valid_o unknown after reset");

endmodule

// ==== rtl/pcs_rx_pkg.sv ====
//////////////////////////////
// Receive PCS shared definitions
// Widths, sync headers, block type codes
// XGMII characters and block kinds
//////////////////////////////

package pcs_rx_pkg;

    // Widths
    localparam int HDR_W     = 2;
    localparam int PAYLOAD_W = 64;
    localparam int XGMII_C_W = 8;

    // Descrambler polynomial x^58 + x^39 + 1
    localparam int SCR_LEN = 58;
    localparam int SCR_TAP = 39;

    // Sync headers
    localparam logic [HDR_W-1:0] HDR_DATA = 2'b01;
    localparam logic [HDR_W-1:0] HDR_CTRL = 2'b10;

    //////////////////////////////
    // Control block type field
    localparam logic [7:0] BT_IDLE  = 8'h1E;
    localparam logic [7:0] BT_START = 8'h78;
    localparam logic [7:0] BT_TERM0 = 8'h87;
    localparam logic [7:0] BT_TERM1 = 8'h99;
    localparam logic [7:0] BT_TERM2 = 8'hAA;
    localparam logic [7:0] BT_TERM3 = 8'hB4;
    localparam logic [7:0] BT_TERM4 = 8'hCC;
    localparam logic [7:0] BT_TERM5 = 8'hD2;
    localparam logic [7:0] BT_TERM6 = 8'hE1;
    localparam logic [7:0] BT_TERM7 = 8'hFF;

    //////////////////////////////
    // XGMII control characters
    localparam logic [7:0] XG_IDLE  = 8'h07;
    localparam logic [7:0] XG_START = 8'hFB;
    localparam logic [7:0] XG_TERM  = 8'hFD;
    localparam logic [7:0] XG_ERROR = 8'hFE;

    // Decoded block class
    typedef enum logic [2:0] {
        BLK_DATA,
        BLK_IDLE,
        BLK_START,
        BLK_TERM,
        BLK_ERROR
    } block_kind_e;

endpackage

// ==== rtl/pcs_rx_top.sv ====
//////////////////////////////
// Receive PCS top level
// Lane reorder, one descrambler and
// one 66b decoder per lane
//////////////////////////////

`timescale 1ns/1ps

module pcs_rx_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                rx_clk_161_13,
    input  logic                                async_reset_n,

    input  logic                                rx_valid_i,
    input  logic [pcs_rx_pkg::HDR_W-1:0]        rx_header_i [NUM_LANES],
    input  logic [pcs_rx_pkg::PAYLOAD_W-1:0]    rx_data_i   [NUM_LANES],
    input  logic [1:0]                          lane_rot_i,
    input  logic                                bypass_descram_i,

    output logic                                xgmii_valid_o,
    output logic [pcs_rx_pkg::XGMII_C_W-1:0]    xgmii_rxc_o [NUM_LANES],
    output logic [pcs_rx_pkg::PAYLOAD_W-1:0]    xgmii_rxd_o [NUM_LANES]
);

    import pcs_rx_pkg::*;

    logic                   ord_valid;
    logic [HDR_W-1:0]       ord_header [NUM_LANES];
    logic [PAYLOAD_W-1:0]   ord_data   [NUM_LANES];
    logic [PAYLOAD_W-1:0]   prev_data;
    logic [PAYLOAD_W-1:0]   hist_data  [NUM_LANES];
    logic [PAYLOAD_W-1:0]   desc_data  [NUM_LANES];
    logic                   lane_valid [NUM_LANES];
    logic [NUM_LANES:0]     term_chain;

    lane_reorder #(
        .NUM_LANES (NUM_LANES)
    ) u_lane_reorder (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .rx_valid_i    (rx_valid_i),
        .rx_header_i   (rx_header_i),
        .rx_data_i     (rx_data_i),
        .lane_rot_i    (lane_rot_i),
        .ord_valid_o   (ord_valid),
        .ord_header_o  (ord_header),
        .ord_data_o    (ord_data),
        .prev_data_o   (prev_data)
    );

    // Nothing precedes lane 0 within a cycle
    assign term_chain[0] = 1'b0;

    //////////////////////////////
    // Per-lane descramble and decode
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        // History comes from the block just before in stream order
        if (k == 0) begin : g_hist_prev
            assign hist_data[k] = prev_data;
        end else begin : g_hist_lane
            assign hist_data[k] = ord_data[k-1];
        end

        rx_descrambler u_descrambler (
            .bypass_descram_i (bypass_descram_i),
            .data_i           (ord_data[k]),
            .history_i        (hist_data[k]),
            .data_o           (desc_data[k])
        );

        block_decoder u_decoder (
            .rx_clk_161_13 (rx_clk_161_13),
            .async_reset_n (async_reset_n),
            .valid_i       (ord_valid),
            .header_i      (ord_header[k]),
            .data_i        (desc_data[k]),
            .term_i        (term_chain[k]),
            .term_o        (term_chain[k+1]),
            .xgmii_valid_o (lane_valid[k]),
            .xgmii_rxc_o   (xgmii_rxc_o[k]),
            .xgmii_rxd_o   (xgmii_rxd_o[k])
        );
    end

    // All lanes share one valid, lane 0 stands for the group
    assign xgmii_valid_o = lane_valid[0];

endmodule

// ==== rtl/rx_descrambler.sv ====
//////////////////////////////
// Self-synchronizing descrambler
// x^58 + x^39 + 1, one 64-bit lane
//////////////////////////////

`timescale 1ns/1ps

module rx_descrambler (
    input  logic                                bypass_descram_i,
    input  logic [pcs_rx_pkg::PAYLOAD_W-1:0]    data_i,
    input  logic [pcs_rx_pkg::PAYLOAD_W-1:0]    history_i,
    output logic [pcs_rx_pkg::PAYLOAD_W-1:0]    data_o
);

    import pcs_rx_pkg::*;

    // Serial order, oldest bit at index 0
    logic [2*PAYLOAD_W-1:0] stream;
    logic [PAYLOAD_W-1:0]   descr;

    assign stream = {data_i, history_i};

    // Taps reach back at most SCR_LEN bits, inside the previous block
    always_comb begin
        for (int i = 0; i < PAYLOAD_W; i++) begin
            descr[i] = stream[PAYLOAD_W + i]
                     ^ stream[PAYLOAD_W + i - SCR_TAP]
                     ^ stream[PAYLOAD_W + i - SCR_LEN];
        end
    end

    assign data_o = bypass_descram_i ? data_i : descr;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the receive PCS testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pcs_rx_top.f --top-module pcs_rx_tb \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vpcs_rx_tb 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "Done: no errors" && exit 0 || exit 1
